//--- Bender.yml
package:
  name: dcache

sources:
  - hw/cache_pkg.sv
  - hw/line_ram.sv
  - hw/dcache_datapath.sv
  - hw/dcache_ctrl.sv
  - hw/mem_model.sv
  - hw/dcache_top.sv
  - target: test
    files:
      - bench/tb_clk.sv
      - bench/dcache_chk.sv
      - bench/dcache_tb.sv

//--- bench/dcache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_chk (
	input logic                  clk,
	input logic                  rst,
	input cache_pkg::cache_req_t i_req,
	input logic                  i_ready,
	input logic                  i_done,
	input cache_pkg::mem_req_t   i_mem_req
);

	// assertion failures so far
	int fire_cnt = 0;

	// the port stays closed while a request completes
	done_without_ready: assert property (@(posedge clk) disable iff (rst)
		!(i_done && i_ready))
	else begin
		$error("o_done and o_ready are high in the same cycle");
		fire_cnt = fire_cnt + 1;
	end

	ready_drops_after_accept: assert property (@(posedge clk) disable iff (rst)
		(i_ready && (i_req.rd || i_req.wr)) |=> !i_ready)
	else begin
		$error("o_ready stayed high after a request was accepted");
		fire_cnt = fire_cnt + 1;
	end

	mem_one_command: assert property (@(posedge clk) disable iff (rst)
		!(i_mem_req.rd && i_mem_req.wr))
	else begin
		$error("memory read and write requested together");
		fire_cnt = fire_cnt + 1;
	end

endmodule

bind dcache_top dcache_chk chk0 (
	.clk(clk), .rst(rst), .i_req(i_req), .i_ready(o_ready), .i_done(o_done),
	.i_mem_req(mem_req)
);

`default_nettype wire

//--- bench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	import cache_pkg::*;

	localparam int MEM_LATENCY = 4;
	localparam int MEM_LINES = 16384;
	localparam int WAIT_LIMIT = 100;
	localparam int RANDOM_OPS = 200;
	localparam int INIT_CYCLES = 32;

	logic clk;
	logic rst;
	cache_req_t req;
	logic ready;
	logic done;
	word_t rdata;

	// one entry per issued request with the oldest first
	string exp_name [$];
	logic exp_is_rd [$];
	word_t exp_word [$];

	// last value written to every word address
	word_t shadow [65536];
	logic [15:0] lfsr;

	tb_clk #(.PERIOD(10)) clk_gen0 (.o_clk(clk));

	dcache_top #(.MEM_LATENCY(MEM_LATENCY), .MEM_LINES(MEM_LINES)) dut0 (
		.clk(clk), .rst(rst), .i_req(req), .o_ready(ready), .o_done(done), .o_rdata(rdata)
	);

	////////////////////////////////////////////////////////////
	// reference model and helpers
	////////////////////////////////////////////////////////////

	// unwritten words read back as zero
	function automatic word_t expected_word(input addr_t addr);
		return shadow[addr];
	endfunction

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[14:0], lfsr[0]};
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("Fail %s: expected %0h, actual %0h",
				name, expected, actual));
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				report_failure("timed out waiting for the cache to become ready");
			end
		end
	endtask

	// cycles counts falling edges from the offer to the one that sees o_done
	task automatic cache_access(input string name, input logic is_wr, input addr_t addr,
			input word_t data, output int cycles);
		wait_ready();
		exp_name.push_back(name);
		exp_is_rd.push_back(!is_wr);
		if (is_wr) begin
			shadow[addr] = data;
			exp_word.push_back(data);
		end else begin
			exp_word.push_back(expected_word(addr));
		end
		req = '{rd: !is_wr, wr: is_wr, addr: addr, wdata: data};
		@(negedge clk);
		req.rd = 1'b0;
		req.wr = 1'b0;
		cycles = 1;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				report_failure($sformatf("timed out waiting for %s to complete", name));
			end
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_name.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				report_failure("expected results were never consumed");
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		string name;
		logic is_rd;
		word_t word;
		if (!rst && done === 1'b1) begin
			if (exp_name.size() == 0) begin
				report_failure("o_done pulsed with no request outstanding");
			end else begin
				name = exp_name.pop_front();
				is_rd = exp_is_rd.pop_front();
				word = exp_word.pop_front();
				if (is_rd) begin
					check_value(name, word, rdata);
				end
			end
		end
		if (dut0.chk0.fire_cnt != 0) begin
			report_failure("a handshake assertion fired");
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		int t;
		addr_t a;
		logic [15:0] op_bits;
		logic [15:0] addr_bits;
		logic [15:0] data_bits;
		rst = 1'b1;
		req = '0;
		lfsr = 16'd76;
		foreach (shadow[i]) begin
			shadow[i] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// init sweep keeps the port closed
		check_value("reset_ready_low", 0, ready);
		check_value("reset_done_low", 0, done);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			check_value("init_done_low", 0, done);
			if (cycles > WAIT_LIMIT) begin
				report_failure("o_ready never rose after reset");
			end
		end while (!ready);
		check_value("init_cycles", INIT_CYCLES, cycles);

		// cold miss on untouched memory
		cache_access("cold_read", 1'b0, 16'h1234, 16'h0000, cycles);
		check_value("cold_read_is_miss", 1, cycles > 2);

		// second access to the same line is a hit
		cache_access("hit_write", 1'b1, 16'h0ab6, 16'hbeef, cycles);
		cache_access("hit_read", 1'b0, 16'h0ab6, 16'h0000, cycles);
		check_value("hit_latency", 2, cycles);

		// three tags in set 9 read back out of order
		for (int k = 0; k < 3; k++) begin
			a = '{tag: tag_t'(k + 5), index: index_t'(9), offset: offset_t'(k)};
			cache_access($sformatf("evict_write_%0d", k), 1'b1, a,
				word_t'(16'h1000 * (k + 1) + 16'h005a), cycles);
		end
		for (int k = 0; k < 3; k++) begin
			t = (k + 2) % 3;
			a = '{tag: tag_t'(t + 5), index: index_t'(9), offset: offset_t'(t)};
			cache_access($sformatf("evict_read_%0d", t), 1'b0, a, 16'h0000, cycles);
		end

		// four tags over four sets force evictions
		for (int i = 0; i < RANDOM_OPS; i++) begin
			take_bits(1, op_bits);
			take_bits(6, addr_bits);
			take_bits(16, data_bits);
			a = '{tag: tag_t'(addr_bits[5:4]), index: index_t'(addr_bits[3:2]),
				offset: offset_t'(addr_bits[1:0])};
			cache_access($sformatf("random_%0d", i), op_bits[0], a, data_bits, cycles);
		end

		wait_drained();
		if (dut0.chk0.fire_cnt != 0) begin
			report_failure("a handshake assertion fired during the run");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock that starts low
module tb_clk #(
	parameter int PERIOD = 10
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

//--- build.f
hw/cache_pkg.sv
hw/line_ram.sv
hw/dcache_datapath.sv
hw/dcache_ctrl.sv
hw/mem_model.sv
hw/dcache_top.sv
bench/tb_clk.sv
bench/dcache_chk.sv
bench/dcache_tb.sv

//--- hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

	////////////////////////////////////////////////////////////
	// geometry
	////////////////////////////////////////////////////////////

	localparam int WORD_W = 16;
	localparam int TAG_W = 9;
	localparam int INDEX_W = 5;
	localparam int OFFSET_W = 2;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;
	localparam int NUM_SETS = 1 << INDEX_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// word 0 sits in the low bits
	typedef logic [LINE_W-1:0] line_data_t;

	// word address with the tag on top
	typedef struct packed {
		tag_t tag;
		index_t index;
		offset_t offset;
	} addr_t;

	typedef struct packed {
		tag_t tag;
		index_t index;
	} line_addr_t;

	////////////////////////////////////////////////////////////
	// entries and requests
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
		line_data_t line_data;
	} way_entry_t;

	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
	} cache_req_t;

	typedef struct packed {
		logic rd;
		logic wr;
		line_addr_t line_addr;
		line_data_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic done;
		line_data_t rdata;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		INIT,
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		FINISH
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  cache_pkg::cache_req_t i_req,
	output logic                  o_ready,
	output logic                  o_done,
	output cache_pkg::cache_req_t o_req_q,
	output cache_pkg::index_t     o_index,
	output logic                  o_we0,
	output logic                  o_we1,
	output cache_pkg::way_entry_t o_way_wdata,
	output logic                  o_lru_we,
	output logic                  o_lru_wdata,
	input  logic                  i_hit,
	input  logic                  i_hit_way,
	input  logic                  i_alloc_way,
	input  cache_pkg::way_entry_t i_victim,
	input  cache_pkg::line_addr_t i_victim_addr,
	input  cache_pkg::way_entry_t i_hit_entry,
	input  cache_pkg::way_entry_t i_fill_entry,
	output cache_pkg::mem_req_t   o_mem_req,
	input  cache_pkg::mem_rsp_t   i_mem_rsp
);

	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	index_t init_cnt;
	cache_req_t req_q;
	logic accept;
	logic init_last;

	assign accept = (state == IDLE) && (i_req.rd || i_req.wr);
	assign init_last = (init_cnt == index_t'(NUM_SETS - 1));

	assign o_ready = (state == IDLE);
	assign o_done = (state == FINISH);
	assign o_req_q = req_q;

	////////////////////////////////////////////////////////////
	// state and counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= INIT;
			init_cnt <= '0;
		end else begin
			state <= next_state;
			if (state == INIT) begin
				init_cnt <= init_cnt + 1'b1;
			end
		end
	end

	// read has priority over write in the held request
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= i_req;
			req_q.wr <= i_req.wr & ~i_req.rd;
		end
	end

	////////////////////////////////////////////////////////////
	// next state and ram / memory controls
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		o_index = req_q.addr.index;
		o_we0 = 1'b0;
		o_we1 = 1'b0;
		o_way_wdata = i_hit_entry;
		o_lru_we = 1'b0;
		o_lru_wdata = 1'b0;
		o_mem_req = '{
			rd: 1'b0,
			wr: 1'b0,
			line_addr: '{tag: req_q.addr.tag, index: req_q.addr.index},
			wdata: i_victim.line_data
		};

		case (state)
			// sweep every set to invalid
			INIT: begin
				o_index = init_cnt;
				o_we0 = 1'b1;
				o_we1 = 1'b1;
				o_way_wdata = '0;
				o_lru_we = 1'b1;
				if (init_last) begin
					next_state = IDLE;
				end
			end

			// set is read at the acceptance edge
			IDLE: begin
				o_index = i_req.addr.index;
				if (accept) begin
					next_state = LOOKUP;
				end
			end

			LOOKUP: begin
				if (i_hit) begin
					o_lru_we = 1'b1;
					o_lru_wdata = ~i_hit_way;
					if (req_q.wr) begin
						o_we0 = ~i_hit_way;
						o_we1 = i_hit_way;
					end
					next_state = FINISH;
				end else if (i_victim.valid && i_victim.dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = REFILL;
				end
			end

			// dirty victim goes out before the refill
			WRITEBACK: begin
				o_mem_req.wr = 1'b1;
				o_mem_req.line_addr = i_victim_addr;
				if (i_mem_rsp.done) begin
					next_state = REFILL;
				end
			end

			REFILL: begin
				o_mem_req.rd = 1'b1;
				if (i_mem_rsp.done) begin
					o_way_wdata = i_fill_entry;
					o_we0 = ~i_alloc_way;
					o_we1 = i_alloc_way;
					o_lru_we = 1'b1;
					o_lru_wdata = ~i_alloc_way;
					next_state = FINISH;
				end
			end

			FINISH: begin
				next_state = IDLE;
			end

			default: begin
				next_state = INIT;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/dcache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath (
	input  cache_pkg::cache_req_t i_req_q,
	input  cache_pkg::way_entry_t i_way0,
	input  cache_pkg::way_entry_t i_way1,
	input  logic                  i_lru,
	input  cache_pkg::line_data_t i_mem_rdata,
	output logic                  o_hit,
	output logic                  o_hit_way,
	output logic                  o_alloc_way,
	output cache_pkg::way_entry_t o_victim,
	output cache_pkg::line_addr_t o_victim_addr,
	output cache_pkg::way_entry_t o_hit_entry,
	output cache_pkg::way_entry_t o_fill_entry,
	output cache_pkg::word_t      o_rdata
);

	import cache_pkg::*;

	logic hit0;
	logic hit1;
	logic alloc_way;
	way_entry_t hit_line;
	way_entry_t victim;
	line_data_t fill_line;

	function automatic word_t select_word(input line_data_t line, input offset_t off);
		return line[int'(off) * WORD_W +: WORD_W];
	endfunction

	function automatic line_data_t merge_word(input line_data_t line, input offset_t off,
			input word_t w);
		line_data_t res;
		res = line;
		res[int'(off) * WORD_W +: WORD_W] = w;
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// tag compare and way choice
	////////////////////////////////////////////////////////////

	assign hit0 = i_way0.valid && (i_way0.tag == i_req_q.addr.tag);
	assign hit1 = i_way1.valid && (i_way1.tag == i_req_q.addr.tag);
	assign o_hit = hit0 | hit1;
	assign o_hit_way = ~hit0;
	assign hit_line = hit0 ? i_way0 : i_way1;

	// empty way first, else the one the lru bit names
	assign alloc_way = !i_way0.valid ? 1'b0 :
		!i_way1.valid ? 1'b1 : i_lru;
	assign o_alloc_way = alloc_way;

	assign victim = alloc_way ? i_way1 : i_way0;
	assign o_victim = victim;
	assign o_victim_addr = '{tag: victim.tag, index: i_req_q.addr.index};

	////////////////////////////////////////////////////////////
	// write merge and fill
	////////////////////////////////////////////////////////////

	assign o_hit_entry = '{
		valid: 1'b1,
		dirty: 1'b1,
		tag: hit_line.tag,
		line_data: merge_word(hit_line.line_data, i_req_q.addr.offset, i_req_q.wdata)
	};

	// a write miss lands its word on top of the fetched line
	assign fill_line = i_req_q.wr ?
		merge_word(i_mem_rdata, i_req_q.addr.offset, i_req_q.wdata) : i_mem_rdata;

	assign o_fill_entry = '{
		valid: 1'b1,
		dirty: i_req_q.wr,
		tag: i_req_q.addr.tag,
		line_data: fill_line
	};

	// read word from the resident line, or straight from memory after a refill
	assign o_rdata = o_hit ? select_word(hit_line.line_data, i_req_q.addr.offset) :
		select_word(i_mem_rdata, i_req_q.addr.offset);

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_LINES = 16384
) (
	input  logic                  clk,
	input  logic                  rst,
	input  cache_pkg::cache_req_t i_req,
	output logic                  o_ready,
	output logic                  o_done,
	output cache_pkg::word_t      o_rdata
);

	import cache_pkg::*;

	cache_req_t req_q;
	index_t index;
	logic we0;
	logic we1;
	logic lru_we;
	logic lru_wdata;
	logic lru_rdata;
	way_entry_t way_wdata;
	way_entry_t way0;
	way_entry_t way1;
	logic hit;
	logic hit_way;
	logic alloc_way;
	way_entry_t victim;
	line_addr_t victim_addr;
	way_entry_t hit_entry;
	way_entry_t fill_entry;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	////////////////////////////////////////////////////////////
	// tag/data and lru storage
	////////////////////////////////////////////////////////////

	line_ram #(.entry_t(way_entry_t), .DEPTH(NUM_SETS)) way0_ram (
		.clk(clk), .i_we(we0), .i_addr(index), .i_wdata(way_wdata), .o_rdata(way0)
	);

	line_ram #(.entry_t(way_entry_t), .DEPTH(NUM_SETS)) way1_ram (
		.clk(clk), .i_we(we1), .i_addr(index), .i_wdata(way_wdata), .o_rdata(way1)
	);

	line_ram #(.entry_t(logic), .DEPTH(NUM_SETS)) lru_ram (
		.clk(clk), .i_we(lru_we), .i_addr(index), .i_wdata(lru_wdata), .o_rdata(lru_rdata)
	);

	dcache_datapath datapath0 (
		.i_req_q(req_q), .i_way0(way0), .i_way1(way1), .i_lru(lru_rdata),
		.i_mem_rdata(mem_rsp.rdata), .o_hit(hit), .o_hit_way(hit_way),
		.o_alloc_way(alloc_way), .o_victim(victim), .o_victim_addr(victim_addr),
		.o_hit_entry(hit_entry), .o_fill_entry(fill_entry), .o_rdata(o_rdata)
	);

	dcache_ctrl ctrl0 (
		.clk(clk), .rst(rst), .i_req(i_req), .o_ready(o_ready), .o_done(o_done),
		.o_req_q(req_q), .o_index(index), .o_we0(we0), .o_we1(we1),
		.o_way_wdata(way_wdata), .o_lru_we(lru_we), .o_lru_wdata(lru_wdata),
		.i_hit(hit), .i_hit_way(hit_way), .i_alloc_way(alloc_way), .i_victim(victim),
		.i_victim_addr(victim_addr), .i_hit_entry(hit_entry), .i_fill_entry(fill_entry),
		.o_mem_req(mem_req), .i_mem_rsp(mem_rsp)
	);

	// backing memory
	mem_model #(.MEM_LATENCY(MEM_LATENCY), .MEM_LINES(MEM_LINES)) mem0 (
		.clk(clk), .rst(rst), .i_req(mem_req), .o_rsp(mem_rsp)
	);

endmodule

`default_nettype wire

//--- hw/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

// read-first RAM with one entry per set
module line_ram #(
	parameter type entry_t = logic,
	parameter int DEPTH = cache_pkg::NUM_SETS
) (
	input  logic              clk,
	input  logic              i_we,
	input  cache_pkg::index_t i_addr,
	input  entry_t            i_wdata,
	output entry_t            o_rdata
);

	entry_t mem [DEPTH];

	// old contents come out when the same address is written
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
		o_rdata <= mem[i_addr];
	end

endmodule

`default_nettype wire

//--- hw/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// line-wide backing store with a fixed access time
module mem_model #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_LINES = 16384
) (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::mem_req_t i_req,
	output cache_pkg::mem_rsp_t o_rsp
);

	import cache_pkg::*;

	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	line_data_t mem [MEM_LINES] = '{default: '0};

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic active;
	logic done;

	assign active = i_req.rd | i_req.wr;
	assign done = busy && (cnt == CNT_W'(MEM_LATENCY));

	// wait for a request, then count out the latency
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (!busy) begin
			if (active) begin
				busy <= 1'b1;
				cnt <= CNT_W'(1);
			end
		end else if (done) begin
			busy <= 1'b0;
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (done && i_req.wr) begin
			mem[i_req.line_addr] <= i_req.wdata;
		end
	end

	assign o_rsp = '{done: done, rdata: mem[i_req.line_addr]};

endmodule

`default_nettype wire
